//--- decodeStage.f
+incdir+tests
common/rv32iPkg.sv
decode/instrDecoder.sv
decode/regFile.sv
decode/branchTarget.sv
logic/decodeStage.sv
tests/decodeStageTb.sv

//--- tests/decodeVectors.svh
// one row per applied instruction
// stimulus: instr, pc, {stall,flush}, wb en/rd/data, ex en/rd/result
// expected: pc, aluSrc, aluOp, branchOp, memOp,
//   ctl {branchFlag,memWr,memRd,regWr,memToReg,jump,illegal}, imm1, imm2, pcDest, rd, rs1, rs2

localparam int NUM_VEC = 19;

vecRow_t vectors [NUM_VEC];

task automatic loadVectors();
    // R-type add, sub with x5 written the same cycle, sra
    vectors[0] = '{32'h002081B3, 32'h100, 2'b00, 1'b0, 5'd0, 32'h0, 1'b0, 5'd0, 32'h0,
        32'h100, 2'd0, 4'd0, 2'd0, 4'h0, 7'h08, 32'h0, 32'h0, 32'h104, 5'd3, 5'd1, 5'd2};
    vectors[1] = '{32'h40628233, 32'h104, 2'b00, 1'b1, 5'd5, 32'h1000, 1'b0, 5'd0, 32'h0,
        32'h104, 2'd0, 4'd1, 2'd0, 4'h0, 7'h08, 32'h0, 32'h0, 32'h108, 5'd4, 5'd5, 5'd6};
    vectors[2] = '{32'h409453B3, 32'h108, 2'b00, 1'b0, 5'd0, 32'h0, 1'b0, 5'd0, 32'h0,
        32'h108, 2'd0, 4'd7, 2'd0, 4'h0, 7'h08, 32'h0, 32'h0, 32'h10C, 5'd7, 5'd8, 5'd9};
    // addi from x0 while x0 is being written, then srai
    vectors[3] = '{32'hFFB00513, 32'h10C, 2'b00, 1'b1, 5'd0, 32'h12345678, 1'b0, 5'd0, 32'h0,
        32'h10C, 2'd1, 4'd0, 2'd0, 4'h0, 7'h08, 32'h0, 32'hFFFFFFFB, 32'h110, 5'd10, 5'd0, 5'd0};
    vectors[4] = '{32'h40365593, 32'h110, 2'b00, 1'b0, 5'd0, 32'h0, 1'b0, 5'd0, 32'h0,
        32'h110, 2'd1, 4'd7, 2'd0, 4'h0, 7'h08, 32'h0, 32'h403, 32'h114, 5'd11, 5'd12, 5'd0};
    // lw, then a stalled sw keeps the load payload as a bubble
    vectors[5] = '{32'hFF872683, 32'h114, 2'b00, 1'b0, 5'd0, 32'h0, 1'b0, 5'd0, 32'h0,
        32'h114, 2'd1, 4'd0, 2'd0, 4'hA, 7'h1C, 32'h0, 32'hFFFFFFF8, 32'h118, 5'd13, 5'd14, 5'd0};
    vectors[6] = '{32'h00F82623, 32'h118, 2'b10, 1'b0, 5'd0, 32'h0, 1'b0, 5'd0, 32'h0,
        32'h114, 2'd1, 4'd0, 2'd0, 4'hA, 7'h04, 32'h0, 32'hFFFFFFF8, 32'h118, 5'd13, 5'd14, 5'd0};
    vectors[7] = '{32'h00F82623, 32'h118, 2'b00, 1'b0, 5'd0, 32'h0, 1'b0, 5'd0, 32'h0,
        32'h118, 2'd1, 4'd0, 2'd0, 4'hA, 7'h20, 32'h0, 32'hC, 32'h11C, 5'd0, 5'd16, 5'd15};
    // stall and flush together
    vectors[8] = '{32'h00F82623, 32'h11C, 2'b11, 1'b0, 5'd0, 32'h0, 1'b0, 5'd0, 32'h0,
        32'h0, 2'd0, 4'd0, 2'd0, 4'h0, 7'h00, 32'h0, 32'h0, 32'h4, 5'd0, 5'd0, 5'd0};
    // blt backwards, lui, auipc, jal
    vectors[9] = '{32'hFF28C8E3, 32'h200, 2'b00, 1'b0, 5'd0, 32'h0, 1'b0, 5'd0, 32'h0,
        32'h200, 2'd0, 4'd3, 2'd1, 4'h0, 7'h40, 32'h0, 32'hFFFFFFF0, 32'h1F0, 5'd0, 5'd17, 5'd18};
    vectors[10] = '{32'hABCDE9B7, 32'h204, 2'b00, 1'b0, 5'd0, 32'h0, 1'b0, 5'd0, 32'h0,
        32'h204, 2'd3, 4'd10, 2'd0, 4'h0, 7'h08, 32'h0, 32'hABCDE000, 32'h208, 5'd19, 5'd0, 5'd0};
    vectors[11] = '{32'h00012A17, 32'h208, 2'b00, 1'b0, 5'd0, 32'h0, 1'b0, 5'd0, 32'h0,
        32'h208, 2'd2, 4'd0, 2'd0, 4'h0, 7'h08, 32'h0, 32'h12000, 32'h20C, 5'd20, 5'd0, 5'd0};
    vectors[12] = '{32'h001000EF, 32'h300, 2'b00, 1'b0, 5'd0, 32'h0, 1'b0, 5'd0, 32'h0,
        32'h300, 2'd2, 4'd0, 2'd1, 4'h0, 7'h0A, 32'h4, 32'h800, 32'hB00, 5'd1, 5'd0, 5'd0};
    // jalr 9(x5): other rd in execute, same rd in execute, then x0 in execute
    vectors[13] = '{32'h009280E7, 32'h304, 2'b00, 1'b0, 5'd0, 32'h0, 1'b1, 5'd6, 32'h5555,
        32'h304, 2'd2, 4'd0, 2'd2, 4'h0, 7'h0A, 32'h4, 32'h9, 32'h1008, 5'd1, 5'd5, 5'd0};
    vectors[14] = '{32'h009280E7, 32'h308, 2'b00, 1'b0, 5'd0, 32'h0, 1'b1, 5'd5, 32'h2000,
        32'h308, 2'd2, 4'd0, 2'd2, 4'h0, 7'h0A, 32'h4, 32'h9, 32'h2008, 5'd1, 5'd5, 5'd0};
    vectors[15] = '{32'h009000E7, 32'h30C, 2'b00, 1'b0, 5'd0, 32'h0, 1'b1, 5'd0, 32'h4000,
        32'h30C, 2'd2, 4'd0, 2'd2, 4'h0, 7'h0A, 32'h4, 32'h9, 32'h8, 5'd1, 5'd0, 5'd0};
    // unknown opcode, plain flush, recovery
    vectors[16] = '{32'hFFFFFFFF, 32'h310, 2'b00, 1'b0, 5'd0, 32'h0, 1'b0, 5'd0, 32'h0,
        32'h310, 2'd0, 4'd0, 2'd0, 4'h0, 7'h01, 32'h0, 32'h0, 32'h314, 5'd0, 5'd0, 5'd0};
    vectors[17] = '{NOP_INSTR, 32'h314, 2'b01, 1'b0, 5'd0, 32'h0, 1'b0, 5'd0, 32'h0,
        32'h0, 2'd0, 4'd0, 2'd0, 4'h0, 7'h00, 32'h0, 32'h0, 32'h4, 5'd0, 5'd0, 5'd0};
    vectors[18] = '{NOP_INSTR, 32'h318, 2'b00, 1'b0, 5'd0, 32'h0, 1'b0, 5'd0, 32'h0,
        32'h318, 2'd1, 4'd0, 2'd0, 4'h0, 7'h08, 32'h0, 32'h0, 32'h31C, 5'd0, 5'd0, 5'd0};
endtask

//--- tests/decodeStageTb.sv
`timescale 1ns/10ps
`default_nettype none

module decodeStageTb;
    import rv32iPkg::*;

    localparam int RESET_CYCLES = 8;
    localparam int WAIT_LIMIT   = 20;

    typedef struct packed {
        word_t      instr;
        word_t      pc;
        logic [1:0] hazard;
        logic       wbEn;
        regAddr_t   wbRd;
        word_t      wbData;
        logic       exEn;
        regAddr_t   exRd;
        word_t      exResult;
        word_t      expPc;
        aluSrc_t    expAluSrc;
        aluOp_t     expAluOp;
        branchOp_t  expBranchOp;
        memOp_t     expMemOp;
        logic [6:0] expCtl;
        word_t      expImm1;
        word_t      expImm2;
        word_t      expPcDest;
        regAddr_t   expRd;
        regAddr_t   expRs1;
        regAddr_t   expRs2;
    } vecRow_t;

    logic      Clk;
    logic      rstN_i;
    word_t     pc_i;
    instr_t    instr_i;
    logic      stall_i;
    logic      flush_i;
    logic      exRegWr_i;
    regAddr_t  exRd_i;
    word_t     exResult_i;
    logic      wbRegWr_i;
    regAddr_t  wbRd_i;
    word_t     wbData_i;
    word_t     pc_o;
    aluSrc_t   aluSrc_o;
    aluOp_t    aluOp_o;
    branchOp_t branchOp_o;
    logic      branchFlag_o;
    logic      memWr_o;
    logic      memRd_o;
    logic      regWr_o;
    logic      memToReg_o;
    logic      jump_o;
    memOp_t    memOp_o;
    word_t     pcDest_o;
    word_t     imm1_o;
    word_t     imm2_o;
    word_t     rs1Data_o;
    word_t     rs2Data_o;
    regAddr_t  rd_o;
    regAddr_t  rs1Addr_o;
    regAddr_t  rs2Addr_o;
    logic      illegal_o;

    // expected register contents
    word_t       regModel [0:31];
    logic [15:0] lfsrState;
    string       stepName;

    `include "decodeVectors.svh"

    decodeStage decodeStage_i (.*);

    initial begin
        Clk = 1'b0;
        forever #2 Clk = ~Clk;
    end

    // ====================
    // helpers
    // ====================

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsrStep(input logic [15:0] s);
        lfsrStep = {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic word_t randomWord();
        word_t w;
        w = '0;
        for (int b = 0; b < 32; b++) begin
            lfsrState = lfsrStep(lfsrState);
            w = {w[30:0], lfsrState[0]};
        end
        return w;
    endfunction

    task automatic stopRun();
        $display("ERRORS FOUND");
        $fatal(1, "decodeStageTb stopped at the first error");
    endtask

    task automatic checkWord(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("FAIL %s: %s got %h expected %h", stepName, name, got, exp);
            stopRun();
        end
    endtask

    task automatic checkAddr(input string name, input regAddr_t got, input regAddr_t exp);
        if (got !== exp) begin
            $display("FAIL %s: %s got %h expected %h", stepName, name, got, exp);
            stopRun();
        end
    endtask

    task automatic checkAluOp(input string name, input aluOp_t got, input aluOp_t exp);
        if (got !== exp) begin
            $display("FAIL %s: %s got %h expected %h", stepName, name, got, exp);
            stopRun();
        end
    endtask

    task automatic checkAluSrc(input string name, input aluSrc_t got, input aluSrc_t exp);
        if (got !== exp) begin
            $display("FAIL %s: %s got %h expected %h", stepName, name, got, exp);
            stopRun();
        end
    endtask

    task automatic checkBranchOp(input string name, input branchOp_t got, input branchOp_t exp);
        if (got !== exp) begin
            $display("FAIL %s: %s got %h expected %h", stepName, name, got, exp);
            stopRun();
        end
    endtask

    task automatic checkMemOp(input string name, input memOp_t got, input memOp_t exp);
        if (got !== exp) begin
            $display("FAIL %s: %s got %h expected %h", stepName, name, got, exp);
            stopRun();
        end
    endtask

    task automatic checkFlag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAIL %s: %s got %h expected %h", stepName, name, got, exp);
            stopRun();
        end
    endtask

    // ====================
    // stimulus and checks
    // ====================

    task automatic checkResetState();
        checkWord("pc_o", pc_o, '0);
        checkFlag("branchFlag_o", branchFlag_o, 1'b0);
        checkFlag("memWr_o", memWr_o, 1'b0);
        checkFlag("memRd_o", memRd_o, 1'b0);
        checkFlag("regWr_o", regWr_o, 1'b0);
        checkFlag("memToReg_o", memToReg_o, 1'b0);
        checkFlag("jump_o", jump_o, 1'b0);
        checkFlag("illegal_o", illegal_o, 1'b0);
    endtask

    // first decoded NOP shows the stage is out of reset
    task automatic waitOutOfReset();
        int cycles;
        cycles = 0;
        while (regWr_o !== 1'b1) begin
            if (cycles == WAIT_LIMIT) begin
                $display("DUT did not leave reset within %0d cycles", WAIT_LIMIT);
                stopRun();
            end
            @(negedge Clk);
            cycles++;
        end
    endtask

    task automatic preloadRegs();
        word_t val;
        for (int r = 1; r < 32; r++) begin
            val = randomWord();
            @(posedge Clk);
            wbRegWr_i <= 1'b1;
            wbRd_i    <= regAddr_t'(r);
            wbData_i  <= val;
            regModel[r] = val;
        end
        @(posedge Clk);
        wbRegWr_i <= 1'b0;
    endtask

    task automatic applyRow(input vecRow_t v);
        instr_i    <= v.instr;
        pc_i       <= v.pc;
        stall_i    <= v.hazard[1];
        flush_i    <= v.hazard[0];
        wbRegWr_i  <= v.wbEn;
        wbRd_i     <= v.wbRd;
        wbData_i   <= v.wbData;
        exRegWr_i  <= v.exEn;
        exRd_i     <= v.exRd;
        exResult_i <= v.exResult;
        // x0 never changes
        if (v.wbEn && v.wbRd != '0) begin
            regModel[v.wbRd] = v.wbData;
        end
    endtask

    task automatic checkRow(input vecRow_t v);
        checkWord("pc_o", pc_o, v.expPc);
        checkAluSrc("aluSrc_o", aluSrc_o, v.expAluSrc);
        checkAluOp("aluOp_o", aluOp_o, v.expAluOp);
        checkBranchOp("branchOp_o", branchOp_o, v.expBranchOp);
        checkMemOp("memOp_o", memOp_o, v.expMemOp);
        checkFlag("branchFlag_o", branchFlag_o, v.expCtl[6]);
        checkFlag("memWr_o", memWr_o, v.expCtl[5]);
        checkFlag("memRd_o", memRd_o, v.expCtl[4]);
        checkFlag("regWr_o", regWr_o, v.expCtl[3]);
        checkFlag("memToReg_o", memToReg_o, v.expCtl[2]);
        checkFlag("jump_o", jump_o, v.expCtl[1]);
        checkFlag("illegal_o", illegal_o, v.expCtl[0]);
        checkWord("imm1_o", imm1_o, v.expImm1);
        checkWord("imm2_o", imm2_o, v.expImm2);
        checkWord("pcDest_o", pcDest_o, v.expPcDest);
        checkAddr("rd_o", rd_o, v.expRd);
        checkAddr("rs1Addr_o", rs1Addr_o, v.expRs1);
        checkAddr("rs2Addr_o", rs2Addr_o, v.expRs2);
        checkWord("rs1Data_o", rs1Data_o, regModel[v.expRs1]);
        checkWord("rs2Data_o", rs2Data_o, regModel[v.expRs2]);
    endtask

    initial begin
        rstN_i     = 1'b0;
        pc_i       = '0;
        instr_i    = NOP_INSTR;
        stall_i    = 1'b0;
        flush_i    = 1'b0;
        exRegWr_i  = 1'b0;
        exRd_i     = '0;
        exResult_i = '0;
        wbRegWr_i  = 1'b0;
        wbRd_i     = '0;
        wbData_i   = '0;
        lfsrState  = 16'd11;
        for (int r = 0; r < 32; r++) begin
            regModel[r] = '0;
        end
        loadVectors();

        repeat (RESET_CYCLES) @(posedge Clk);
        @(negedge Clk);
        stepName = "reset";
        checkResetState();
        @(posedge Clk);
        rstN_i <= 1'b1;
        waitOutOfReset();
        preloadRegs();

        // each row is captured one edge after it is driven
        for (int i = 0; i < NUM_VEC; i++) begin
            stepName = $sformatf("row %0d", i);
            @(posedge Clk);
            applyRow(vectors[i]);
            @(posedge Clk);
            @(negedge Clk);
            checkRow(vectors[i]);
        end

        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

//--- logic/decodeStage.sv
`timescale 1ns/10ps
`default_nettype none

module decodeStage (
    input  wire                       Clk,
    input  wire                       rstN_i,

    // from fetch and hazard logic
    input  wire rv32iPkg::word_t      pc_i,
    input  wire rv32iPkg::instr_t     instr_i,
    input  wire                       stall_i,
    input  wire                       flush_i,

    // execute result for jalr forwarding
    input  wire                       exRegWr_i,
    input  wire rv32iPkg::regAddr_t   exRd_i,
    input  wire rv32iPkg::word_t      exResult_i,

    // writeback port
    input  wire                       wbRegWr_i,
    input  wire rv32iPkg::regAddr_t   wbRd_i,
    input  wire rv32iPkg::word_t      wbData_i,

    // decode/execute boundary
    output rv32iPkg::word_t           pc_o,
    output rv32iPkg::aluSrc_t         aluSrc_o,
    output rv32iPkg::aluOp_t          aluOp_o,
    output rv32iPkg::branchOp_t       branchOp_o,
    output logic                      branchFlag_o,
    output logic                      memWr_o,
    output logic                      memRd_o,
    output logic                      regWr_o,
    output logic                      memToReg_o,
    output logic                      jump_o,
    output rv32iPkg::memOp_t          memOp_o,
    output rv32iPkg::word_t           pcDest_o,
    output rv32iPkg::word_t           imm1_o,
    output rv32iPkg::word_t           imm2_o,
    output rv32iPkg::word_t           rs1Data_o,
    output rv32iPkg::word_t           rs2Data_o,
    output rv32iPkg::regAddr_t        rd_o,
    output rv32iPkg::regAddr_t        rs1Addr_o,
    output rv32iPkg::regAddr_t        rs2Addr_o,
    output logic                      illegal_o
);
    import rv32iPkg::*;

    word_t     decImm1;
    word_t     decImm2;
    regAddr_t  decRd;
    regAddr_t  decRs1;
    regAddr_t  decRs2;
    aluSrc_t   decAluSrc;
    aluOp_t    decAluOp;
    branchOp_t decBranchOp;
    memOp_t    decMemOp;
    logic      decBranchFlag;
    logic      decMemWr;
    logic      decMemRd;
    logic      decRegWr;
    logic      decMemToReg;
    logic      decJump;
    logic      decIllegal;
    word_t     rs1Fwd;

    // ====================
    // blocks
    // ====================

    instrDecoder instrDecoder_i (
        .instr_i      (instr_i),
        .pc_i         (pc_i),
        .imm1_o       (decImm1),
        .imm2_o       (decImm2),
        .rd_o         (decRd),
        .rs1_o        (decRs1),
        .rs2_o        (decRs2),
        .aluSrc_o     (decAluSrc),
        .aluOp_o      (decAluOp),
        .branchOp_o   (decBranchOp),
        .memOp_o      (decMemOp),
        .branchFlag_o (decBranchFlag),
        .memWr_o      (decMemWr),
        .memRd_o      (decMemRd),
        .regWr_o      (decRegWr),
        .memToReg_o   (decMemToReg),
        .jump_o       (decJump),
        .illegal_o    (decIllegal)
    );

    // read ports use the registered addresses
    regFile regFile_i (
        .Clk       (Clk),
        .rstN_i    (rstN_i),
        .rs1Addr_i (rs1Addr_o),
        .rs2Addr_i (rs2Addr_o),
        .wrAddr_i  (wbRd_i),
        .wrData_i  (wbData_i),
        .wrEn_i    (wbRegWr_i),
        .rs1Data_o (rs1Data_o),
        .rs2Data_o (rs2Data_o)
    );

    branchTarget branchTarget_i (
        .branchOp_i (branchOp_o),
        .pc_i       (pc_o),
        .rs1Data_i  (rs1Fwd),
        .imm_i      (imm2_o),
        .dest_o     (pcDest_o)
    );

    // ====================
    // jalr forwarding
    // ====================

    // rs1 may still be in flight in execute
    assign rs1Fwd = (branchOp_o[1] && exRegWr_i && exRd_i == rs1Addr_o && rs1Addr_o != '0)
                    ? exResult_i : rs1Data_o;

    // ====================
    // pipeline register
    // ====================

    always_ff @(posedge Clk or negedge rstN_i) begin
        if (!rstN_i) begin
            {pc_o, aluSrc_o, aluOp_o, branchOp_o, branchFlag_o, memWr_o, memRd_o,
             regWr_o, memToReg_o, jump_o, memOp_o, imm1_o, imm2_o,
             rd_o, rs1Addr_o, rs2Addr_o, illegal_o} <= '0;
        end else if (flush_i) begin
            // flush beats stall
            {pc_o, aluSrc_o, aluOp_o, branchOp_o, branchFlag_o, memWr_o, memRd_o,
             regWr_o, memToReg_o, jump_o, memOp_o, imm1_o, imm2_o,
             rd_o, rs1Addr_o, rs2Addr_o, illegal_o} <= '0;
        end else if (stall_i) begin
            // hold the payload and kill the side effects
            memWr_o <= 1'b0;
            memRd_o <= 1'b0;
            regWr_o <= 1'b0;
            jump_o  <= 1'b0;
        end else begin
            pc_o         <= pc_i;
            aluSrc_o     <= decAluSrc;
            aluOp_o      <= decAluOp;
            branchOp_o   <= decBranchOp;
            branchFlag_o <= decBranchFlag;
            memWr_o      <= decMemWr;
            memRd_o      <= decMemRd;
            regWr_o      <= decRegWr;
            memToReg_o   <= decMemToReg;
            jump_o       <= decJump;
            memOp_o      <= decMemOp;
            imm1_o       <= decImm1;
            imm2_o       <= decImm2;
            rd_o         <= decRd;
            rs1Addr_o    <= decRs1;
            rs2Addr_o    <= decRs2;
            illegal_o    <= decIllegal;
        end
    end

    flushKillsEnables: assert property (@(posedge Clk) disable iff (!rstN_i)
        flush_i |=> !(memWr_o || memRd_o || regWr_o || memToReg_o || jump_o || branchFlag_o))
        else $error("decodeStage: enable active after flush");

endmodule

`default_nettype wire

//--- decode/branchTarget.sv
`timescale 1ns/10ps
`default_nettype none

module branchTarget (
    input  wire rv32iPkg::branchOp_t  branchOp_i,
    input  wire rv32iPkg::word_t      pc_i,
    input  wire rv32iPkg::word_t      rs1Data_i,
    input  wire rv32iPkg::word_t      imm_i,
    output rv32iPkg::word_t           dest_o
);
    import rv32iPkg::*;

    word_t regSum;

    assign regSum = rs1Data_i + imm_i;

    always_comb begin
        case (branchOp_i)
            BR_PC_REL:  dest_o = pc_i + imm_i;
            // jalr drops the lsb of the sum
            BR_REG_REL: dest_o = {regSum[31:1], 1'b0};
            // fall-through
            default:    dest_o = pc_i + 32'd4;
        endcase
    end

    always_comb begin
        if (branchOp_i == BR_REG_REL) begin
            assert final (dest_o[0] == 1'b0)
                else $error("branchTarget: odd jalr target %h", dest_o);
        end
    end

endmodule

`default_nettype wire

//--- decode/regFile.sv
`timescale 1ns/10ps
`default_nettype none

module regFile (
    input  wire                       Clk,
    input  wire                       rstN_i,
    input  wire rv32iPkg::regAddr_t   rs1Addr_i,
    input  wire rv32iPkg::regAddr_t   rs2Addr_i,
    input  wire rv32iPkg::regAddr_t   wrAddr_i,
    input  wire rv32iPkg::word_t      wrData_i,
    input  wire                       wrEn_i,
    output rv32iPkg::word_t           rs1Data_o,
    output rv32iPkg::word_t           rs2Data_o
);
    import rv32iPkg::*;

    // x0 is cleared on reset and never written
    word_t regs [0:31];

    always_ff @(posedge Clk or negedge rstN_i) begin
        if (!rstN_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn_i && wrAddr_i != '0) begin
            regs[wrAddr_i] <= wrData_i;
        end
    end

    // without a write bypass a same-cycle read sees the old value
    assign rs1Data_o = regs[rs1Addr_i];
    assign rs2Data_o = regs[rs2Addr_i];

    x0ReadsZero: assert property (@(posedge Clk) disable iff (!rstN_i)
        (rs1Addr_i == '0) |-> (rs1Data_o == '0))
        else $error("regFile: x0 read returned %h", rs1Data_o);

endmodule

`default_nettype wire

//--- decode/instrDecoder.sv
`timescale 1ns/10ps
`default_nettype none

module instrDecoder (
    input  wire rv32iPkg::instr_t     instr_i,
    input  wire rv32iPkg::word_t      pc_i,
    output rv32iPkg::word_t           imm1_o,
    output rv32iPkg::word_t           imm2_o,
    output rv32iPkg::regAddr_t        rd_o,
    output rv32iPkg::regAddr_t        rs1_o,
    output rv32iPkg::regAddr_t        rs2_o,
    output rv32iPkg::aluSrc_t         aluSrc_o,
    output rv32iPkg::aluOp_t          aluOp_o,
    output rv32iPkg::branchOp_t       branchOp_o,
    output rv32iPkg::memOp_t          memOp_o,
    output logic                      branchFlag_o,
    output logic                      memWr_o,
    output logic                      memRd_o,
    output logic                      regWr_o,
    output logic                      memToReg_o,
    output logic                      jump_o,
    output logic                      illegal_o
);
    import rv32iPkg::*;

    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      immI;
    word_t      immS;
    word_t      immB;
    word_t      immU;
    word_t      immJ;
    aluOp_t     arithOp;
    logic       arithOk;
    logic       unknown;

    // opcode and funct fields sit at the same bits in every format
    assign funct3 = instr_i.rType.funct3;
    assign funct7 = instr_i.rType.funct7;

    // sign-extended immediates
    assign immI = {{20{instr_i.iType.imm11_0[11]}}, instr_i.iType.imm11_0};
    assign immS = {{20{instr_i.sType.imm11_5[6]}}, instr_i.sType.imm11_5,
                   instr_i.sType.imm4_0};
    assign immB = {{19{instr_i.bType.imm12}}, instr_i.bType.imm12, instr_i.bType.imm11,
                   instr_i.bType.imm10_5, instr_i.bType.imm4_1, 1'b0};
    assign immU = {instr_i.uType.imm31_12, 12'b0};
    assign immJ = {{11{instr_i.jType.imm20}}, instr_i.jType.imm20, instr_i.jType.imm19_12,
                   instr_i.jType.imm11, instr_i.jType.imm10_1, 1'b0};

    // arithmetic op for OP and OP-IMM
    // funct7 only matters for register ops and for shifts
    always_comb begin
        arithOp = ALU_ADD;
        arithOk = (instr_i.rType.opcode == OP_OPIMM) || (funct7 == F7_BASE);
        case (funct3)
            3'b000: begin
                if (instr_i.rType.opcode == OP_OP && funct7 == F7_ALT) begin
                    arithOp = ALU_SUB;
                    arithOk = 1'b1;
                end
            end
            3'b001: begin
                arithOp = ALU_SLL;
                arithOk = (funct7 == F7_BASE);
            end
            3'b010: arithOp = ALU_SLT;
            3'b011: arithOp = ALU_SLTU;
            3'b100: arithOp = ALU_XOR;
            3'b101: begin
                arithOp = (funct7 == F7_ALT) ? ALU_SRA : ALU_SRL;
                arithOk = (funct7 == F7_BASE) || (funct7 == F7_ALT);
            end
            3'b110: arithOp = ALU_OR;
            default: arithOp = ALU_AND;
        endcase
    end

    always_comb begin
        unknown      = 1'b0;
        imm1_o       = '0;
        imm2_o       = '0;
        rd_o         = '0;
        rs1_o        = '0;
        rs2_o        = '0;
        aluSrc_o     = SRC_RS1_RS2;
        aluOp_o      = ALU_ADD;
        branchOp_o   = BR_NONE;
        memOp_o      = MEM_NONE;
        branchFlag_o = 1'b0;
        memWr_o      = 1'b0;
        memRd_o      = 1'b0;
        regWr_o      = 1'b0;
        memToReg_o   = 1'b0;
        jump_o       = 1'b0;

        case (instr_i.rType.opcode)
            OP_LUI: begin
                imm2_o   = immU;
                aluSrc_o = SRC_ZERO_IMM;
                aluOp_o  = ALU_PASSB;
                regWr_o  = 1'b1;
            end
            OP_AUIPC: begin
                imm2_o   = immU;
                aluSrc_o = SRC_PC_IMM;
                regWr_o  = 1'b1;
            end
            OP_JAL: begin
                // link value is pc + 4
                imm1_o     = 32'd4;
                imm2_o     = immJ;
                aluSrc_o   = SRC_PC_IMM;
                branchOp_o = BR_PC_REL;
                jump_o     = 1'b1;
                regWr_o    = 1'b1;
            end
            OP_JALR: begin
                imm1_o     = 32'd4;
                imm2_o     = immI;
                rs1_o      = instr_i.iType.rs1;
                aluSrc_o   = SRC_PC_IMM;
                branchOp_o = BR_REG_REL;
                jump_o     = 1'b1;
                regWr_o    = 1'b1;
                unknown    = (funct3 != 3'b000);
            end
            OP_BRANCH: begin
                imm2_o       = immB;
                rs1_o        = instr_i.bType.rs1;
                rs2_o        = instr_i.bType.rs2;
                branchOp_o   = BR_PC_REL;
                branchFlag_o = 1'b1;
                // eq/ne compare by subtraction, the rest by set-less-than
                case (funct3[2:1])
                    2'b00: aluOp_o = ALU_SUB;
                    2'b10: aluOp_o = ALU_SLT;
                    2'b11: aluOp_o = ALU_SLTU;
                    default: unknown = 1'b1;
                endcase
            end
            OP_LOAD: begin
                imm2_o     = immI;
                rs1_o      = instr_i.iType.rs1;
                aluSrc_o   = SRC_RS1_IMM;
                memOp_o    = {1'b1, funct3};
                memRd_o    = 1'b1;
                memToReg_o = 1'b1;
                regWr_o    = 1'b1;
                unknown    = (funct3 == 3'b011) || (funct3[2:1] == 2'b11);
            end
            OP_STORE: begin
                imm2_o   = immS;
                rs1_o    = instr_i.sType.rs1;
                rs2_o    = instr_i.sType.rs2;
                aluSrc_o = SRC_RS1_IMM;
                memOp_o  = {1'b1, funct3};
                memWr_o  = 1'b1;
                unknown  = (funct3 > 3'b010);
            end
            OP_OPIMM: begin
                imm2_o   = immI;
                rs1_o    = instr_i.iType.rs1;
                aluSrc_o = SRC_RS1_IMM;
                aluOp_o  = arithOp;
                regWr_o  = 1'b1;
                unknown  = !arithOk;
            end
            OP_OP: begin
                rs1_o   = instr_i.rType.rs1;
                rs2_o   = instr_i.rType.rs2;
                aluOp_o = arithOp;
                regWr_o = 1'b1;
                unknown = !arithOk;
            end
            default: unknown = 1'b1;
        endcase

        // an illegal word must not touch memory, registers or the PC
        if (unknown) begin
            branchOp_o   = BR_NONE;
            memOp_o      = MEM_NONE;
            branchFlag_o = 1'b0;
            memWr_o      = 1'b0;
            memRd_o      = 1'b0;
            regWr_o      = 1'b0;
            memToReg_o   = 1'b0;
            jump_o       = 1'b0;
        end
        if (regWr_o) begin
            rd_o = instr_i.rType.rd;
        end
        illegal_o = unknown;
    end

    always_comb begin
        if (!$isunknown(pc_i)) begin
            assert final (pc_i[1:0] == 2'b00)
                else $error("instrDecoder: misaligned pc %h", pc_i);
        end
        assert final (!(memWr_o && memRd_o))
            else $error("instrDecoder: load and store decoded together");
    end

endmodule

`default_nettype wire

//--- common/rv32iPkg.sv
`default_nettype none

package rv32iPkg;

    // ====================
    // base types
    // ====================

    typedef logic [31:0] word_t;
    typedef logic [4:0]  regAddr_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [3:0]  aluOp_t;
    typedef logic [1:0]  aluSrc_t;
    typedef logic [1:0]  branchOp_t;
    typedef logic [3:0]  memOp_t;

    // ====================
    // encodings
    // ====================

    // major opcodes, RV32I base set only
    localparam opcode_t OP_LUI    = 7'b0110111;
    localparam opcode_t OP_AUIPC  = 7'b0010111;
    localparam opcode_t OP_JAL    = 7'b1101111;
    localparam opcode_t OP_JALR   = 7'b1100111;
    localparam opcode_t OP_BRANCH = 7'b1100011;
    localparam opcode_t OP_LOAD   = 7'b0000011;
    localparam opcode_t OP_STORE  = 7'b0100011;
    localparam opcode_t OP_OPIMM  = 7'b0010011;
    localparam opcode_t OP_OP     = 7'b0110011;

    // funct7 variants
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

    localparam aluOp_t ALU_ADD   = 4'd0;
    localparam aluOp_t ALU_SUB   = 4'd1;
    localparam aluOp_t ALU_SLL   = 4'd2;
    localparam aluOp_t ALU_SLT   = 4'd3;
    localparam aluOp_t ALU_SLTU  = 4'd4;
    localparam aluOp_t ALU_XOR   = 4'd5;
    localparam aluOp_t ALU_SRL   = 4'd6;
    localparam aluOp_t ALU_SRA   = 4'd7;
    localparam aluOp_t ALU_OR    = 4'd8;
    localparam aluOp_t ALU_AND   = 4'd9;
    localparam aluOp_t ALU_PASSB = 4'd10;

    // operand A / operand B selection
    localparam aluSrc_t SRC_RS1_RS2  = 2'd0;
    localparam aluSrc_t SRC_RS1_IMM  = 2'd1;
    localparam aluSrc_t SRC_PC_IMM   = 2'd2;
    localparam aluSrc_t SRC_ZERO_IMM = 2'd3;

    // top bit means the target is built from rs1
    localparam branchOp_t BR_NONE    = 2'd0;
    localparam branchOp_t BR_PC_REL  = 2'd1;
    localparam branchOp_t BR_REG_REL = 2'd2;

    // access flag in bit 3, funct3 below it
    localparam memOp_t MEM_NONE = 4'b0000;

    // ====================
    // instruction formats
    // ====================

    typedef struct packed {
        logic [6:0] funct7;
        regAddr_t   rs2;
        regAddr_t   rs1;
        logic [2:0] funct3;
        regAddr_t   rd;
        opcode_t    opcode;
    } rType_t;

    typedef struct packed {
        logic [11:0] imm11_0;
        regAddr_t    rs1;
        logic [2:0]  funct3;
        regAddr_t    rd;
        opcode_t     opcode;
    } iType_t;

    typedef struct packed {
        logic [6:0] imm11_5;
        regAddr_t   rs2;
        regAddr_t   rs1;
        logic [2:0] funct3;
        logic [4:0] imm4_0;
        opcode_t    opcode;
    } sType_t;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        regAddr_t   rs2;
        regAddr_t   rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        opcode_t    opcode;
    } bType_t;

    typedef struct packed {
        logic [19:0] imm31_12;
        regAddr_t    rd;
        opcode_t     opcode;
    } uType_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        regAddr_t   rd;
        opcode_t    opcode;
    } jType_t;

    // one fetched word, six ways to slice it
    typedef union packed {
        rType_t rType;
        iType_t iType;
        sType_t sType;
        bType_t bType;
        uType_t uType;
        jType_t jType;
    } instr_t;

    // addi x0, x0, 0
    localparam word_t NOP_INSTR = 32'h0000_0013;

endpackage

`default_nettype wire
